/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_ctrl
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation finished: FAIL" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/spi_slave_model.sv */
`timescale 1ns/1ps

// Mode 0 SPI slave, MSB first in both directions
module spi_slave_model (
    input  logic               sclk,
    input  logic               cs_n,
    input  logic               mosi,
    output logic               miso,
    input  spi_pkg::spi_byte_t reply,
    output spi_pkg::spi_byte_t captured,  // Last byte seen on mosi
    output logic               frame_done // Short pulse when cs_n rises
);

    spi_pkg::spi_byte_t tx_sh;
    spi_pkg::spi_byte_t rx_sh;

    assign miso = tx_sh[7];

    initial begin
        tx_sh      = '0;
        rx_sh      = '0;
        captured   = '0;
        frame_done = 1'b0;
        forever begin
            @(negedge cs_n);
            tx_sh = reply; // First reply bit out before the first rising edge
            rx_sh = '0;
            while (!cs_n) begin
                @(posedge sclk or negedge sclk or posedge cs_n);
                if (!cs_n && sclk) begin
                    rx_sh = {rx_sh[6:0], mosi}; // Sample on rising
                end else if (!cs_n) begin
                    tx_sh = {tx_sh[6:0], 1'b0}; // Next bit while sclk low
                end
            end
            captured   = rx_sh;
            frame_done = 1'b1;
            #1 frame_done = 1'b0;
        end
    end

endmodule

/* bench/spi_trace.txt */
# op addr data expected, all hex. W write, R read and compare, X transfer data with reply expected
# P wait for idle, data is the byte the slave should have captured
R 0 00 04
R 8 00 00
R C 00 00
X 4 A5 3C
W 0 00 00
R 0 00 00
X 4 5A C3
W 0 09 00
R 0 00 09
X 4 96 69
W 4 11 00
W 4 22 00
R 8 00 03
R 8 00 01
P 8 11 00
R C 00 69
R 8 00 00
W 0 04 00
X 4 00 FF
X 4 FF 00

/* bench/tb_spi_ctrl.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module tb_spi_ctrl;

    logic               clk;
    logic               rst;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    spi_pkg::wb_addr_t  wb_adr;
    spi_pkg::wb_data_t  wb_dat_w;
    spi_pkg::wb_data_t  wb_dat_r;
    logic               wb_ack;
    logic               sclk;
    logic               cs_n;
    logic               mosi;
    logic               miso;
    spi_pkg::spi_byte_t reply;
    spi_pkg::spi_byte_t captured;
    logic               frame_done;

    int errors     = 0;
    int mon_errors = 0; // From the sclk monitor
    int cycle_cnt  = 0;
    int cur_div    = 0; // Divider the engine should be using
    int high_len   = 0;
    int pulses     = 0;
    int frames     = 0;
    bit timed_out  = 1'b0;

    spi_ctrl_top spi_ctrl_top_i (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso)
    );

    spi_slave_model spi_slave_model_i (
        .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .reply(reply), .captured(captured), .frame_done(frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    always @(posedge frame_done) frames <= frames + 1;

    // Measure every sclk high pulse at the stable falling clk edge
    always @(negedge clk) begin
        if (!rst && !cs_n && sclk) begin
            high_len = high_len + 1;
        end else if (high_len != 0) begin
            if (high_len != cur_div + 1) begin
                $display("Mismatch at %0t: sclk high cycles expected %0d, got %0d",
                         $time, cur_div + 1, high_len);
                mon_errors = mon_errors + 1;
            end
            high_len = 0;
            pulses   = pulses + 1;
        end
        if (cs_n && pulses != 0) begin
            if (pulses != 8) begin
                $display("Mismatch at %0t: sclk pulses per frame expected 8, got %0d",
                         $time, pulses);
                mon_errors = mon_errors + 1;
            end
            pulses = 0;
        end
    end

    // One classic cycle returning the data seen in the ack cycle
    task automatic bus_cycle(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        rdata = '0;
        if (timed_out) return;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited = waited + 1;
        end while (!wb_ack && waited < 16);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("Timeout: no ack within 16 cycles for access to offset 0x%h", adr);
            timed_out = 1'b1;
        end
    endtask

    // Poll STATUS until busy clears
    task automatic wait_idle();
        int          start;
        logic [31:0] st;
        start = cycle_cnt;
        st    = 32'd1;
        while (st[0] && !timed_out) begin
            if (cycle_cnt - start > 2000) begin
                $display("Timeout: busy still set after 2000 cycles");
                timed_out = 1'b1;
            end else begin
                bus_cycle(1'b0, `SPI_REG_STATUS, 32'd0, st);
            end
        end
    endtask

    initial begin
        int           fd;
        int           n;
        int           frames_before;
        byte          op;
        logic [31:0]  f_addr;
        logic [31:0]  f_data;
        logic [31:0]  f_exp;
        logic [31:0]  rd;
        logic [1023:0] junk;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        reply = '0;
        cur_div = int'(`SPI_DIV_RESET);
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        if (cs_n !== 1'b1) begin
            $display("Mismatch at %0t: cs_n expected 1, got %b", $time, cs_n);
            errors = errors + 1;
        end
        if (sclk !== 1'b0) begin
            $display("Mismatch at %0t: sclk expected 0, got %b", $time, sclk);
            errors = errors + 1;
        end
        if (mosi !== 1'b0) begin
            $display("Mismatch at %0t: mosi expected 0, got %b", $time, mosi);
            errors = errors + 1;
        end
        fd = $fopen("bench/spi_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/spi_trace.txt");
            errors = errors + 1;
        end else begin
            while (!timed_out) begin
                n = $fscanf(fd, " %c", op);
                if (n != 1) break;
                if (op == "#") begin
                    void'($fgets(junk, fd)); // Column description
                    continue;
                end
                n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                if (n != 3) begin
                    $display("Malformed line in the trace file for operation %c", op);
                    errors = errors + 1;
                    break;
                end
                if (op == "W") begin
                    bus_cycle(1'b1, f_addr[3:0], f_data, rd);
                    if (f_addr[3:0] == `SPI_REG_DIV) cur_div = int'(f_data[7:0]);
                end else if (op == "R") begin
                    bus_cycle(1'b0, f_addr[3:0], 32'd0, rd);
                    if (!timed_out && rd !== f_exp) begin
                        $display("Mismatch at %0t: wb_dat_r at 0x%h expected 0x%h, got 0x%h",
                                 $time, f_addr[3:0], f_exp, rd);
                        errors = errors + 1;
                    end
                end else if (op == "X") begin
                    frames_before = frames;
                    reply = f_exp[7:0];
                    bus_cycle(1'b1, f_addr[3:0], f_data, rd);
                    wait_idle();
                    bus_cycle(1'b0, `SPI_REG_RX, 32'd0, rd);
                    if (!timed_out && captured !== f_data[7:0]) begin
                        $display("Mismatch at %0t: captured expected 0x%h, got 0x%h",
                                 $time, f_data[7:0], captured);
                        errors = errors + 1;
                    end
                    if (!timed_out && rd !== f_exp) begin
                        $display("Mismatch at %0t: RX expected 0x%h, got 0x%h", $time, f_exp, rd);
                        errors = errors + 1;
                    end
                    if (!timed_out && frames != frames_before + 1) begin
                        $display("Mismatch at %0t: frame_done count expected 1, got %0d",
                                 $time, frames - frames_before);
                        errors = errors + 1;
                    end
                end else if (op == "P") begin
                    wait_idle();
                    if (!timed_out && captured !== f_data[7:0]) begin
                        $display("Mismatch at %0t: captured expected 0x%h, got 0x%h",
                                 $time, f_data[7:0], captured);
                        errors = errors + 1;
                    end
                end else begin
                    $display("Unknown operation in the trace file: %c", op);
                    errors = errors + 1;
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        if (timed_out) errors = errors + 1;
        $display("Errors: %0d (bus %0d, sclk monitor %0d)",
                 errors + mon_errors, errors, mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* common/spi_byte_if.sv */
`timescale 1ns/1ps

// Single byte request between register file and serial engine
interface spi_byte_if;

    logic               start;   // One-cycle pulse, only while busy is low
    spi_pkg::spi_byte_t tx_byte;
    spi_pkg::spi_div_t  div;
    logic               busy;    // High from the cycle after start to the end of the frame
    spi_pkg::spi_byte_t rx_byte; // Stable while busy is low

    modport requester (
        output start,
        output tx_byte,
        output div,
        input  busy,
        input  rx_byte
    );

    modport engine (
        input  start,
        input  tx_byte,
        input  div,
        output busy,
        output rx_byte
    );

endinterface

/* common/spi_pkg.sv */
`include "spi_settings.svh"

package spi_pkg;

    // One byte on the serial side
    typedef logic [7:0] spi_byte_t;

    // Half-period divider, sclk = clk / (2 * (div + 1))
    typedef logic [7:0] spi_div_t;

    // Register file addressing and data
    typedef logic [`SPI_WB_AW-1:0] wb_addr_t;
    typedef logic [`SPI_WB_DW-1:0] wb_data_t;

    // Serial engine states
    typedef enum logic [1:0] {
        IDLE,   // cs_n high, waiting for start
        SETUP,  // cs_n low, bit 7 on mosi
        SHIFT,  // sclk toggling
        FINISH  // One cycle before release
    } spi_state_t;

endpackage

/* common/spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Wishbone port widths
`define SPI_WB_AW 4
`define SPI_WB_DW 32

// Register byte offsets
`define SPI_REG_DIV    4'h0
`define SPI_REG_TX     4'h4
`define SPI_REG_STATUS 4'h8
`define SPI_REG_RX     4'hC

`define SPI_DIV_RESET 8'd4 // Half period of 5 clk cycles

`endif

/* flist.f */
+incdir+common
common/spi_pkg.sv
common/spi_byte_if.sv
hw/spi_wb_regs.sv
spi_master/spi_master.sv
hw/spi_ctrl_top.sv
bench/spi_slave_model.sv
bench/tb_spi_ctrl.sv

/* hw/spi_ctrl_top.sv */
`timescale 1ns/1ps

// SPI master with Wishbone classic slave port
module spi_ctrl_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  spi_pkg::wb_addr_t wb_adr,
    input  spi_pkg::wb_data_t wb_dat_w,
    output spi_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    output logic              sclk,
    output logic              cs_n,
    output logic              mosi,
    input  logic              miso
);

    spi_byte_if byte_req_if ();

    // Bus side
    spi_wb_regs spi_wb_regs_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .byte_req (byte_req_if.requester)
    );

    // Serial side
    spi_master spi_master_i (
        .clk      (clk),
        .rst      (rst),
        .byte_req (byte_req_if.engine),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso)
    );

endmodule

/* hw/spi_wb_regs.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

// Wishbone classic register file for the SPI master
module spi_wb_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  spi_pkg::wb_addr_t wb_adr,
    input  spi_pkg::wb_data_t wb_dat_w,
    output spi_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    spi_byte_if.requester     byte_req
);

    logic               req_new;   // Request seen and not yet acked
    logic               wr_tx;
    logic               tx_accept; // TX write that actually starts a frame
    logic               overflow;
    spi_pkg::spi_div_t  div_q;
    spi_pkg::spi_byte_t tx_q;

    assign req_new   = wb_cyc && wb_stb && !wb_ack;
    assign wr_tx     = req_new && wb_we && (wb_adr == `SPI_REG_TX);
    assign tx_accept = wr_tx && !byte_req.busy;

    assign byte_req.div     = div_q;
    assign byte_req.tx_byte = tx_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack         <= 1'b0;
            byte_req.start <= 1'b0;
            div_q          <= `SPI_DIV_RESET;
            overflow       <= 1'b0;
        end else begin
            wb_ack         <= req_new;
            byte_req.start <= tx_accept; // Lines up with the ack

            if (req_new && wb_we && (wb_adr == `SPI_REG_DIV)) begin
                div_q <= wb_dat_w[7:0];
            end

            if (req_new && !wb_we && (wb_adr == `SPI_REG_STATUS)) begin
                overflow <= 1'b0; // Cleared by reading
            end else if (wr_tx && !tx_accept) begin
                overflow <= 1'b1; // Byte dropped while the engine is busy
            end
        end
    end

    // Byte in flight only changes when a frame is accepted
    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_q <= wb_dat_w[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (req_new && !wb_we) begin
            case (wb_adr)
                `SPI_REG_DIV:    wb_dat_r <= spi_pkg::wb_data_t'(div_q);
                `SPI_REG_STATUS: wb_dat_r <= spi_pkg::wb_data_t'({overflow, byte_req.busy});
                `SPI_REG_RX:     wb_dat_r <= spi_pkg::wb_data_t'(byte_req.rx_byte);
                default:         wb_dat_r <= '0; // TX is write only
            endcase
        end
    end

    // Each request gets a single ack
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

    // Engine must be idle when a frame is requested
    start_only_idle: assert property (@(posedge clk) disable iff (rst)
        byte_req.start |-> !byte_req.busy);

endmodule

/* spi_master/spi_master.sv */
`timescale 1ns/1ps

// Single byte SPI master, mode 0, MSB first
module spi_master (
    input  logic       clk,
    input  logic       rst,
    spi_byte_if.engine byte_req,
    output logic       sclk,
    output logic       cs_n,
    output logic       mosi,
    input  logic       miso
);

    spi_pkg::spi_state_t state;
    spi_pkg::spi_div_t   div_q;    // Divider latched at start
    spi_pkg::spi_div_t   half_cnt; // clk cycles within a half period
    logic [2:0]          bit_cnt;  // Falling edges seen
    spi_pkg::spi_byte_t  tx_sh;
    spi_pkg::spi_byte_t  rx_sh;
    logic                half_end;
    logic                rise_edge;
    logic                fall_edge;

    assign half_end  = (half_cnt == div_q);
    assign rise_edge = half_end && ((state == spi_pkg::SETUP) ||
                                    ((state == spi_pkg::SHIFT) && !sclk));
    assign fall_edge = half_end && (state == spi_pkg::SHIFT) && sclk;

    assign byte_req.busy = (state != spi_pkg::IDLE);
    assign mosi          = (state == spi_pkg::IDLE) ? 1'b0 : tx_sh[7];

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= spi_pkg::IDLE;
            sclk             <= 1'b0;
            cs_n             <= 1'b1;
            half_cnt         <= '0;
            bit_cnt          <= '0;
            byte_req.rx_byte <= '0;
        end else begin
            case (state)
                spi_pkg::IDLE: begin
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                    if (byte_req.start) begin
                        state <= spi_pkg::SETUP;
                        cs_n  <= 1'b0;
                    end
                end
                spi_pkg::SETUP: begin
                    // Bit 7 already on mosi, wait one half period
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk     <= 1'b1;
                        state    <= spi_pkg::SHIFT;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                spi_pkg::SHIFT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk     <= !sclk;
                        if (sclk) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= spi_pkg::FINISH; // Eighth falling edge
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                spi_pkg::FINISH: begin
                    cs_n             <= 1'b1;
                    byte_req.rx_byte <= rx_sh;
                    state            <= spi_pkg::IDLE;
                end
                default: state <= spi_pkg::IDLE;
            endcase
        end
    end

    // Shift registers and latched divider
    always_ff @(posedge clk) begin
        if ((state == spi_pkg::IDLE) && byte_req.start) begin
            div_q <= byte_req.div;
            tx_sh <= byte_req.tx_byte;
        end
        if (rise_edge) begin
            rx_sh <= {rx_sh[6:0], miso}; // Sample on sclk rising
        end
        if (fall_edge) begin
            tx_sh <= {tx_sh[6:0], 1'b0}; // Next bit while sclk low
        end
    end

    // No clock pulses outside a frame
    sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
        cs_n |-> !sclk);

    // Select and busy move together, register file sees the frame as cs_n does
    busy_tracks_cs: assert property (@(posedge clk) disable iff (rst)
        (state != spi_pkg::FINISH) |-> (byte_req.busy == !cs_n));

endmodule
